// ==== noc_req_pkg.sv ====
`default_nettype none

package noc_req_pkg;

    // --------------------
    // sizes
    // --------------------

    localparam int id_count         = 16;  // AXI IDs served by the NI
    localparam int id_width         = 4;
    localparam int flit_count_width = 3;

    typedef logic [id_count-1:0] id_vec_t;  // one bit per id
    typedef logic [id_width-1:0] id_t;

    // flits per request piece, as seen by the link layer
    localparam logic [flit_count_width-1:0] req_header_flits        = flit_count_width'(1);
    localparam logic [flit_count_width-1:0] write_req_payload_flits = flit_count_width'(1);

    // --------------------
    // encodings
    // --------------------

    // position of a flit inside a packet
    typedef enum logic [1:0] {
        flit_head    = 2'b00,
        flit_payload = 2'b01,
        flit_tail    = 2'b10,
        flit_single  = 2'b11
    } flit_seq_t;

    // arbiter decision
    typedef enum logic [2:0] {
        op_none       = 3'd0,
        op_read       = 3'd1,
        op_write      = 3'd2,
        op_read_ovfl  = 3'd3,  // read blocked by the outstanding limit
        op_write_ovfl = 3'd4   // write blocked by the outstanding limit
    } req_op_t;

    // --------------------
    // bundles
    // --------------------

    typedef struct packed {
        req_op_t op;
        id_t     id;
    } grant_t;

    // per-id queue emptiness
    typedef struct packed {
        id_vec_t ar;
        id_vec_t aw;
        id_vec_t wd;
    } queue_empty_t;

    // per-id pop pulses, one cycle each
    typedef struct packed {
        id_vec_t ar;
        id_vec_t aw;
        id_vec_t wd;
    } queue_pop_t;

    // flit control toward the link layer
    typedef struct packed {
        logic                        send_message;
        logic                        is_payload;
        logic                        sample_header;   // latch ar/aw fields
        logic                        sample_payload;  // latch a wd beat
        logic                        write_select;
        flit_seq_t                   flit_sequence;
        logic [flit_count_width-1:0] num_flits;
    } tx_ctrl_t;

endpackage

`default_nettype wire

// ==== req_id_arbiter.sv ====
`default_nettype none

module req_id_arbiter (
    input  noc_req_pkg::queue_empty_t queue_empty,
    input  noc_req_pkg::id_vec_t      rd_max,
    input  noc_req_pkg::id_vec_t      wr_max,
    input  noc_req_pkg::grant_t       prev_grant,
    output noc_req_pkg::grant_t       grant
);
    import noc_req_pkg::*;

    id_vec_t rd_ready;  // read address waiting
    id_vec_t wr_ready;  // write address and data both waiting
    grant_t  pick;      // choice before the outstanding limit check

    assign rd_ready = ~queue_empty.ar;
    assign wr_ready = ~queue_empty.aw & ~queue_empty.wd;

    // --------------------
    // round-robin search
    // --------------------

    always_comb
    begin
        id_t  idx;
        logic found;

        pick  = '{op: op_none, id: prev_grant.id};
        found = 1'b0;
        idx   = prev_grant.id;

        // previous id gets another turn only after idle or a read
        if (prev_grant.op == op_none)
        begin
            if (rd_ready[prev_grant.id])
            begin
                pick.op = op_read;
                found   = 1'b1;
            end
            else if (wr_ready[prev_grant.id])
            begin
                pick.op = op_write;
                found   = 1'b1;
            end
        end
        else if (prev_grant.op == op_read && wr_ready[prev_grant.id])
        begin
            pick.op = op_write;  // read then write on the same id
            found   = 1'b1;
        end

        // ids after the previous one, wrap is free since id_count fills id_t
        for (int k = 1; k < id_count; k++)
        begin
            idx = prev_grant.id + id_t'(k);
            if (!found && rd_ready[idx])
            begin
                pick  = '{op: op_read, id: idx};
                found = 1'b1;
            end
            else if (!found && wr_ready[idx])
            begin
                pick  = '{op: op_write, id: idx};
                found = 1'b1;
            end
        end

        // nobody else waiting, back to the previous id
        if (!found)
        begin
            if (wr_ready[prev_grant.id])
                pick.op = op_write;
            else if (rd_ready[prev_grant.id])
                pick.op = op_read;
        end
    end

    // --------------------
    // outstanding limit
    // --------------------

    always_comb
    begin
        grant = pick;
        if (pick.op == op_read && rd_max[pick.id])
            grant.op = op_read_ovfl;   // counter full, request stays queued
        else if (pick.op == op_write && wr_max[pick.id])
            grant.op = op_write_ovfl;
    end

endmodule

`default_nettype wire

// ==== request_sequencer.sv ====
`default_nettype none

module request_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  noc_req_pkg::grant_t       grant,
    input  noc_req_pkg::queue_empty_t queue_empty,
    input  logic                      last_beat,
    input  logic                      tx_gone,
    output noc_req_pkg::grant_t       prev_grant,
    output noc_req_pkg::queue_pop_t   queue_pop,
    output noc_req_pkg::tx_ctrl_t     tx,
    output noc_req_pkg::id_t          curr_tid,
    output noc_req_pkg::id_vec_t      incr_rd,
    output noc_req_pkg::id_vec_t      incr_wr,
    output noc_req_pkg::id_vec_t      ovfl_rd,
    output noc_req_pkg::id_vec_t      ovfl_wr
);
    import noc_req_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write_header,
        st_read_header,
        st_write_payload,
        st_write_pause,
        st_write_last
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   take_grant;  // record the idle decision
    logic   wd_ready;    // write data available for the current id
    id_t    cur_id;

    assign cur_id   = prev_grant.id;
    assign wd_ready = !queue_empty.wd[cur_id];
    assign curr_tid = tx.sample_header ? grant.id : cur_id;  // new id shows while sampling

    // --------------------
    // registers
    // --------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= st_idle;
            prev_grant <= '{op: op_none, id: '0};
        end
        else
        begin
            state <= state_nxt;
            if (take_grant)
                prev_grant <= grant;
        end
    end

    // --------------------
    // next state, outputs
    // --------------------

    always_comb
    begin
        state_nxt        = state;
        take_grant       = 1'b0;
        queue_pop        = '0;
        tx               = '0;
        tx.flit_sequence = flit_head;
        incr_rd          = '0;
        incr_wr          = '0;
        ovfl_rd          = '0;
        ovfl_wr          = '0;

        case (state)
            st_idle:
            begin
                take_grant = (grant.op != op_none);  // overflow decisions count too
                case (grant.op)
                    op_read:
                    begin
                        tx.sample_header       = 1'b1;
                        queue_pop.ar[grant.id] = 1'b1;
                        incr_rd[grant.id]      = 1'b1;
                        state_nxt              = st_read_header;
                    end
                    op_write:
                    begin
                        tx.sample_header       = 1'b1;
                        tx.write_select        = 1'b1;
                        queue_pop.aw[grant.id] = 1'b1;
                        incr_wr[grant.id]      = 1'b1;
                        state_nxt              = st_write_header;
                    end
                    op_read_ovfl:  ovfl_rd[grant.id] = 1'b1;  // nothing popped
                    op_write_ovfl: ovfl_wr[grant.id] = 1'b1;
                    default:
                    begin
                        // no request waiting
                    end
                endcase
            end

            st_read_header:
            begin
                tx.send_message  = 1'b1;
                tx.flit_sequence = flit_single;
                tx.num_flits     = req_header_flits;
                if (tx_gone)
                    state_nxt = st_idle;
            end

            st_write_header:
            begin
                tx.send_message  = 1'b1;
                tx.write_select  = 1'b1;
                tx.num_flits     = req_header_flits;
                if (tx_gone)
                begin
                    // first beat was checked by the arbiter
                    tx.sample_payload    = 1'b1;
                    queue_pop.wd[cur_id] = 1'b1;
                    state_nxt            = last_beat ? st_write_last : st_write_payload;
                end
            end

            st_write_payload:
            begin
                tx.send_message  = 1'b1;
                tx.is_payload    = 1'b1;
                tx.write_select  = 1'b1;
                tx.flit_sequence = flit_payload;
                tx.num_flits     = write_req_payload_flits;
                if (tx_gone && wd_ready)
                begin
                    tx.sample_payload    = 1'b1;
                    queue_pop.wd[cur_id] = 1'b1;
                    state_nxt            = last_beat ? st_write_last : st_write_payload;
                end
                else if (tx_gone)
                    state_nxt = st_write_pause;  // data ran dry
            end

            st_write_pause:
            begin
                tx.is_payload    = 1'b1;         // link stays in payload mode
                tx.write_select  = 1'b1;
                tx.flit_sequence = flit_payload;
                tx.num_flits     = write_req_payload_flits;
                if (wd_ready)
                begin
                    tx.sample_payload    = 1'b1;
                    queue_pop.wd[cur_id] = 1'b1;
                    state_nxt            = last_beat ? st_write_last : st_write_payload;
                end
            end

            st_write_last:
            begin
                tx.send_message  = 1'b1;
                tx.is_payload    = 1'b1;
                tx.write_select  = 1'b1;
                tx.flit_sequence = flit_tail;
                tx.num_flits     = write_req_payload_flits;
                if (tx_gone)
                    state_nxt = st_idle;
            end

            default: state_nxt = st_idle;
        endcase
    end

endmodule

`default_nettype wire

// ==== outstanding_counter_bank.sv ====
`default_nettype none

module outstanding_counter_bank #(
    parameter int log_max = 0  // up to 2**log_max in flight per id
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  noc_req_pkg::id_vec_t incr,
    input  noc_req_pkg::id_vec_t decr,
    input  noc_req_pkg::id_vec_t ovfl_req,
    output noc_req_pkg::id_vec_t at_max,
    output noc_req_pkg::id_vec_t ovfl,
    output noc_req_pkg::id_vec_t unfl,
    output noc_req_pkg::id_vec_t busy
);
    import noc_req_pkg::*;

    typedef logic [log_max:0] count_t;

    localparam count_t max_count = count_t'(1) << log_max;

    count_t count [id_count];

    // --------------------
    // status
    // --------------------

    always_comb
    begin
        for (int i = 0; i < id_count; i++)
        begin
            at_max[i] = (count[i] == max_count);
            busy[i]   = (count[i] != '0);  // response still owed
        end
    end

    // --------------------
    // counters
    // --------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ovfl <= '0;
            unfl <= '0;
            for (int i = 0; i < id_count; i++)
                count[i] <= '0;
        end
        else
        begin
            ovfl <= ovfl_req;
            unfl <= '0;
            for (int i = 0; i < id_count; i++)
            begin
                // an increment wins over a same-cycle decrement
                if (incr[i] && !at_max[i])
                    count[i] <= count[i] + count_t'(1);
                else if (decr[i] && count[i] != '0)
                    count[i] <= count[i] - count_t'(1);
                else if (decr[i])
                    unfl[i] <= 1'b1;  // response without a request
            end
        end
    end

endmodule

`default_nettype wire

// ==== axi_ni_request.sv ====
`default_nettype none

module axi_ni_request #(
    parameter int log_max_outs_rd = 0,
    parameter int log_max_outs_wr = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  noc_req_pkg::queue_empty_t queue_empty,
    input  logic                      last_beat,
    input  logic                      tx_gone,
    input  noc_req_pkg::id_vec_t      decr_rd,   // read response seen
    input  noc_req_pkg::id_vec_t      decr_wr,   // write response seen
    output noc_req_pkg::queue_pop_t   queue_pop,
    output noc_req_pkg::tx_ctrl_t     tx,
    output noc_req_pkg::id_t          curr_tid,
    output noc_req_pkg::id_vec_t      rd_ovfl,
    output noc_req_pkg::id_vec_t      wr_ovfl,
    output noc_req_pkg::id_vec_t      rd_unfl,
    output noc_req_pkg::id_vec_t      wr_unfl,
    output noc_req_pkg::id_vec_t      response_awaited
);
    import noc_req_pkg::*;

    grant_t  grant;
    grant_t  prev_grant;
    id_vec_t rd_max;
    id_vec_t wr_max;
    id_vec_t incr_rd;
    id_vec_t incr_wr;
    id_vec_t ovfl_rd;    // blocked read, before the bank register
    id_vec_t ovfl_wr;
    id_vec_t rd_busy;
    id_vec_t wr_busy;

    req_id_arbiter u_arbiter (
        .queue_empty (queue_empty),
        .rd_max      (rd_max),
        .wr_max      (wr_max),
        .prev_grant  (prev_grant),
        .grant       (grant)
    );

    request_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .grant       (grant),
        .queue_empty (queue_empty),
        .last_beat   (last_beat),
        .tx_gone     (tx_gone),
        .prev_grant  (prev_grant),
        .queue_pop   (queue_pop),
        .tx          (tx),
        .curr_tid    (curr_tid),
        .incr_rd     (incr_rd),
        .incr_wr     (incr_wr),
        .ovfl_rd     (ovfl_rd),
        .ovfl_wr     (ovfl_wr)
    );

    outstanding_counter_bank #(.log_max(log_max_outs_rd)) rd_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .incr     (incr_rd),
        .decr     (decr_rd),
        .ovfl_req (ovfl_rd),
        .at_max   (rd_max),
        .ovfl     (rd_ovfl),
        .unfl     (rd_unfl),
        .busy     (rd_busy)
    );

    outstanding_counter_bank #(.log_max(log_max_outs_wr)) wr_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .incr     (incr_wr),
        .decr     (decr_wr),
        .ovfl_req (ovfl_wr),
        .at_max   (wr_max),
        .ovfl     (wr_ovfl),
        .unfl     (wr_unfl),
        .busy     (wr_busy)
    );

    assign response_awaited = rd_busy | wr_busy;  // any request in flight on that id

endmodule

`default_nettype wire

// ==== tb_axi_ni_request.sv ====
`default_nettype none

module tb_axi_ni_request;
    timeunit 1ns;
    timeprecision 1ps;

    import noc_req_pkg::*;

    typedef enum {k_read, k_write, k_pause, k_ovfl, k_rr, k_unfl} kind_t;

    typedef struct {
        string       name;
        kind_t       kind;
        int          id;
        int          beats;       // write burst length
        int          wd_pre;      // wd beats queued before the request
        logic [15:0] mask;        // ids with a read queued, round-robin rows
        int          extra_decr;  // decr_wr pulses on an idle id
        int          exp_ar;
        int          exp_aw;
        int          exp_wd;
        int          exp_flits;
        logic [31:0] exp_pat;     // flit_sequence codes, oldest in the high bits
        int          exp_ovfl;
        int          exp_unfl;
        int          exp_busy;    // response_awaited[id] before cleanup
    } row_t;

    localparam int row_count  = 8;
    localparam int max_cycles = row_count * 40;

    logic         clk;
    logic         rst_n;
    queue_empty_t queue_empty;
    logic         last_beat;
    logic         tx_gone;
    id_vec_t      decr_rd;
    id_vec_t      decr_wr;
    queue_pop_t   queue_pop;
    tx_ctrl_t     tx;
    id_t          curr_tid;
    id_vec_t      rd_ovfl;
    id_vec_t      wr_ovfl;
    id_vec_t      rd_unfl;
    id_vec_t      wr_unfl;
    id_vec_t      response_awaited;

    // queue model and row bookkeeping
    int          ar_cnt [id_count];
    int          aw_cnt [id_count];
    int          wd_cnt [id_count];
    int          rd_out [id_count];
    int          wr_out [id_count];
    int          beats_left;
    int          refill;      // wd beats added once the pause shows
    int          gone_wait;
    int          cycles;
    int          errors;
    int          n_ar;
    int          n_aw;
    int          n_wd;
    int          n_flit;
    int          n_ovfl;
    int          n_unfl;
    int          n_wsel_bad;
    int          n_hdr;       // sample_header pulses
    int          n_spl;       // sample_payload pulses
    int          n_nflit_bad;
    int          n_tid_bad;
    int          n_flag_bad;  // ovfl or unfl on the wrong id or bank
    logic [31:0] flit_pat;
    logic        saw_pause;
    logic        ovfl_decr_done;
    logic        dut_active;
    logic        cur_is_write;
    kind_t       cur_kind;
    int          cur_id;
    int          last_id;
    id_vec_t     pend_decr_rd;
    id_vec_t     pend_decr_wr;
    id_vec_t     resp_snap;
    int          order [$];   // ids of ar pops in this row
    row_t        rows [row_count];

    axi_ni_request #(
        .log_max_outs_rd (0),
        .log_max_outs_wr (4)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .queue_empty      (queue_empty),
        .last_beat        (last_beat),
        .tx_gone          (tx_gone),
        .decr_rd          (decr_rd),
        .decr_wr          (decr_wr),
        .queue_pop        (queue_pop),
        .tx               (tx),
        .curr_tid         (curr_tid),
        .rd_ovfl          (rd_ovfl),
        .wr_ovfl          (wr_ovfl),
        .rd_unfl          (rd_unfl),
        .wr_unfl          (wr_unfl),
        .response_awaited (response_awaited)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("Error %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic queues_idle();
        logic idle;
        idle = (refill == 0);
        for (int i = 0; i < id_count; i++)
            if (ar_cnt[i] != 0 || aw_cnt[i] != 0 || wd_cnt[i] != 0)
                idle = 1'b0;
        return idle;
    endfunction

    // --------------------
    // one clock cycle
    // --------------------

    // sample at the falling edge, drive at the rising edge
    task automatic step();
        logic         nxt_gone;
        queue_empty_t qe;
        @(negedge clk);
        for (int i = 0; i < id_count; i++)
        begin
            if (queue_pop.ar[i])
            begin
                ar_cnt[i]--;
                rd_out[i]++;
                n_ar++;
                last_id = i;
                order.push_back(i);
            end
            if (queue_pop.aw[i])
            begin
                aw_cnt[i]--;
                wr_out[i]++;
                n_aw++;
                last_id = i;
            end
            if (queue_pop.wd[i])
            begin
                wd_cnt[i]--;
                n_wd++;
                beats_left--;
            end
            if (rd_ovfl[i] && i == cur_id)
                n_ovfl++;
            else if (rd_ovfl[i])
                n_flag_bad++;
            if (wr_unfl[i] && i == cur_id)
                n_unfl++;
            else if (wr_unfl[i])
                n_flag_bad++;
            if (wr_ovfl[i] || rd_unfl[i])
                n_flag_bad++;
        end
        resp_snap  = response_awaited;
        dut_active = tx.send_message || tx.is_payload || tx.sample_header;
        if (tx.sample_header)
            n_hdr++;
        if (tx.sample_payload)
            n_spl++;
        if (dut_active && curr_tid !== id_t'(last_id))
            n_tid_bad++;  // new id while sampling, held id afterwards

        // link side accepts a flit after 0 to 3 cycles
        nxt_gone = 1'b0;
        if (tx_gone && tx.send_message)
        begin
            n_flit++;
            flit_pat = {flit_pat[29:0], tx.flit_sequence};
            if (tx.write_select != cur_is_write)
                n_wsel_bad++;
            if (tx.num_flits != 1)
                n_nflit_bad++;  // one flit per header or payload piece
            gone_wait = $urandom % 4;
        end
        else if (tx.send_message)
        begin
            if (gone_wait == 0)
                nxt_gone = 1'b1;
            else
                gone_wait--;
        end

        if (tx.is_payload && !tx.send_message)
        begin
            saw_pause       = 1'b1;
            wd_cnt[cur_id] += refill;  // data arrives again
            refill          = 0;
        end
        if (cur_kind == k_ovfl && n_ovfl > 0 && !ovfl_decr_done)
        begin
            pend_decr_rd[cur_id] = 1'b1;  // read response frees the slot
            ovfl_decr_done       = 1'b1;
        end

        @(posedge clk);
        for (int i = 0; i < id_count; i++)
        begin
            qe.ar[i] = (ar_cnt[i] == 0);
            qe.aw[i] = (aw_cnt[i] == 0);
            qe.wd[i] = (wd_cnt[i] == 0);
            if (pend_decr_rd[i] && rd_out[i] > 0)
                rd_out[i]--;
            if (pend_decr_wr[i] && wr_out[i] > 0)
                wr_out[i]--;
        end
        queue_empty  <= qe;
        last_beat    <= (beats_left == 1);
        tx_gone      <= nxt_gone;
        decr_rd      <= pend_decr_rd;
        decr_wr      <= pend_decr_wr;
        pend_decr_rd  = '0;
        pend_decr_wr  = '0;

        cycles++;
    endtask

    // --------------------
    // one table row
    // --------------------

    task automatic run_row(input row_t r);
        int      exp_q [$];
        int      idx;
        logic    owed;
        n_ar           = 0;
        n_aw           = 0;
        n_wd           = 0;
        n_flit         = 0;
        n_ovfl         = 0;
        n_unfl         = 0;
        n_wsel_bad     = 0;
        n_hdr          = 0;
        n_spl          = 0;
        n_nflit_bad    = 0;
        n_tid_bad      = 0;
        n_flag_bad     = 0;
        flit_pat       = '0;
        saw_pause      = 1'b0;
        ovfl_decr_done = 1'b0;
        cur_id         = r.id;
        cur_kind       = r.kind;
        cur_is_write   = (r.kind == k_write || r.kind == k_pause);
        beats_left     = 0;
        order.delete();

        // expected grant order: ids after the last one, wrapping, last one at the end
        for (int k = 1; k <= id_count; k++)
        begin
            idx = (last_id + k) % id_count;
            if (r.mask[idx])
                exp_q.push_back(idx);
        end

        case (r.kind)
            k_read:  ar_cnt[r.id] += 1;
            k_ovfl:  ar_cnt[r.id] += 2;  // second read hits the limit
            k_rr:
                for (int i = 0; i < id_count; i++)
                    if (r.mask[i])
                        ar_cnt[i] += 1;
            k_unfl:
                for (int n = 0; n < r.extra_decr; n++)
                begin
                    pend_decr_wr[r.id] = 1'b1;
                    step();
                end
            default:
            begin
                aw_cnt[r.id] += 1;
                wd_cnt[r.id] += r.wd_pre;
                refill        = r.beats - r.wd_pre;
                beats_left    = r.beats;
            end
        endcase

        do
            step();
        while (!(n_flit >= r.exp_flits && queues_idle() && !dut_active));
        repeat (3) step();

        check_value({r.name, " ar pops"}, r.exp_ar, n_ar);
        check_value({r.name, " aw pops"}, r.exp_aw, n_aw);
        check_value({r.name, " wd pops"}, r.exp_wd, n_wd);
        check_value({r.name, " sample_header"}, r.exp_ar + r.exp_aw, n_hdr);
        check_value({r.name, " sample_payload"}, r.exp_wd, n_spl);
        check_value({r.name, " flits"}, r.exp_flits, n_flit);
        check_value({r.name, " flit sequence"}, r.exp_pat, flit_pat);
        check_value({r.name, " num_flits"}, 0, n_nflit_bad);
        check_value({r.name, " write_select"}, 0, n_wsel_bad);
        check_value({r.name, " curr_tid"}, 0, n_tid_bad);
        check_value({r.name, " overflow"}, r.exp_ovfl, int'(n_ovfl > 0));
        check_value({r.name, " underflow"}, r.exp_unfl, n_unfl);
        check_value({r.name, " stray flags"}, 0, n_flag_bad);
        check_value({r.name, " pause"}, int'(r.kind == k_pause), int'(saw_pause));
        check_value({r.name, " response_awaited"}, r.exp_busy, int'(resp_snap[r.id]));
        if (r.kind == k_rr)
        begin
            check_value({r.name, " grant count"}, exp_q.size(), order.size());
            for (int i = 0; i < exp_q.size() && i < order.size(); i++)
                check_value({r.name, " grant order"}, exp_q[i], order[i]);
        end

        // answer everything still in flight
        do
        begin
            owed = 1'b0;
            for (int i = 0; i < id_count; i++)
            begin
                pend_decr_rd[i] = (rd_out[i] > 0);
                pend_decr_wr[i] = (wr_out[i] > 0);
                owed = owed | pend_decr_rd[i] | pend_decr_wr[i];
            end
            step();
        end
        while (owed);
        repeat (2) step();
        check_value({r.name, " responses cleared"}, 0, resp_snap);
    endtask

    // --------------------
    // watchdog
    // --------------------

    initial
    begin
        wait (cycles > max_cycles);
        $display("timeout: the DUT did not finish the tests within %0d cycles", max_cycles);
        $display("errors: %0d", errors);
        $display("TEST FAIL");
        $finish;
    end

    // --------------------
    // main
    // --------------------

    initial
    begin
        rst_n        = 1'b0;
        queue_empty  = '1;
        last_beat    = 1'b0;
        tx_gone      = 1'b0;
        decr_rd      = '0;
        decr_wr      = '0;
        pend_decr_rd = '0;
        pend_decr_wr = '0;
        resp_snap    = '0;
        for (int i = 0; i < id_count; i++)
        begin
            ar_cnt[i] = 0;
            aw_cnt[i] = 0;
            wd_cnt[i] = 0;
            rd_out[i] = 0;
            wr_out[i] = 0;
        end
        refill = 0;
        cycles = 0;
        errors = 0;
        last_id = 0;
        cur_id = 0;
        cur_kind = k_read;
        void'($urandom(96626));
        gone_wait = $urandom % 4;

        // name, kind, id, beats, wd_pre, mask, extra_decr,
        // ar, aw, wd, flits, pattern, ovfl, unfl, busy
        rows[0] = '{"read_id3", k_read, 3, 0, 0, 16'h0, 0, 1, 0, 0, 1, 32'h3, 0, 0, 1};
        rows[1] = '{"write3_id5", k_write, 5, 3, 3, 16'h0, 0, 0, 1, 3, 4, 32'h16, 0, 0, 1};
        rows[2] = '{"write1_id5", k_write, 5, 1, 1, 16'h0, 0, 0, 1, 1, 2, 32'h2, 0, 0, 1};
        rows[3] = '{"pause4_id9", k_pause, 9, 4, 2, 16'h0, 0, 0, 1, 4, 5, 32'h56, 0, 0, 1};
        rows[4] = '{"round_robin", k_rr, 10, 0, 0, 16'h8421, 0, 4, 0, 0, 4, 32'hff, 0, 0, 1};
        rows[5] = '{"rd_ovfl_id7", k_ovfl, 7, 0, 0, 16'h0, 0, 2, 0, 0, 2, 32'hf, 1, 0, 1};
        rows[6] = '{"wr_unfl_id12", k_unfl, 12, 0, 0, 16'h0, 1, 0, 0, 0, 0, 32'h0, 0, 1, 0};
        rows[7] = '{"write2_id0", k_write, 0, 2, 2, 16'h0, 0, 0, 1, 2, 3, 32'h6, 0, 0, 1};

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < row_count; r++)
            run_row(rows[r]);

        $display("errors: %0d in %0d tests, %0d cycles", errors, row_count, cycles);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_ni_request.f ====
noc_req_pkg.sv
req_id_arbiter.sv
request_sequencer.sv
outstanding_counter_bank.sv
axi_ni_request.sv
tb_axi_ni_request.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_axi_ni_request \
    -f axi_ni_request.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
